// ==== hdl/filter_defines.svh ====
`ifndef FILTER_DEFINES_SVH
`define FILTER_DEFINES_SVH

// Clock stages from host pins to flash pins, synchronizer included
`define FILT_FWD_DELAY 4

// Command header on data line 0
`define FILT_ADDR_W 24
`define FILT_OPC_BITS 8

`endif

// ==== hdl/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

    // Flash opcodes the guard knows by name
    typedef enum logic [7:0] {
        OPC_WRSR      = 8'h01,
        OPC_PP        = 8'h02,
        OPC_READ      = 8'h03,
        OPC_WRDI      = 8'h04,
        OPC_WREN      = 8'h06,
        OPC_FAST_READ = 8'h0B,
        OPC_SE_4K     = 8'h20,
        OPC_DOR       = 8'h3B,
        OPC_CE_ALT    = 8'h60,
        OPC_RSTEN     = 8'h66,
        OPC_QOR       = 8'h6B,
        OPC_RST       = 8'h99,
        OPC_DIOR      = 8'hBB,
        OPC_CE        = 8'hC7,
        OPC_BE_64K    = 8'hD8,
        OPC_QIOR      = 8'hEB
    } opcode_e;

    // Read class covers the single, dual and quad read variants.
    // Modify class needs an address check before it may pass.
    typedef enum logic [1:0] {
        CLS_READ      = 2'd0,
        CLS_WREN      = 2'd1,
        CLS_MODIFY    = 2'd2,
        CLS_FORBIDDEN = 2'd3
    } cmd_class_e;

endpackage

// ==== hdl/filter_report_pkg.sv ====
package filter_report_pkg;

    // Decision of one checker stage
    // NONE means the stage has no say on this frame
    typedef enum logic [1:0] {
        VERD_NONE  = 2'd0,
        VERD_PASS  = 2'd1,
        VERD_BLOCK = 2'd2
    } verdict_e;

    // Carried in the violation report
    typedef enum logic {
        RSN_OPCODE  = 1'b0,
        RSN_ADDRESS = 1'b1
    } block_reason_e;

endpackage

// ==== hdl/spi_bit_sampler.sv ====
`include "filter_defines.svh"

module spi_bit_sampler (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      host_sck_i,
    input  logic                      host_csb_i,
    input  logic                      host_sd0_i,
    output logic                      frame_start_o,
    output logic                      frame_end_o,
    output logic                      opc_done_o,
    output logic                      addr_done_o,
    output logic [`FILT_OPC_BITS-1:0] opcode_o,
    output logic [`FILT_ADDR_W-1:0]   addr_o
);

    localparam int HDR_W = `FILT_OPC_BITS + `FILT_ADDR_W;
    localparam int CNT_W = $clog2(HDR_W + 1);
    localparam logic [CNT_W-1:0] OPC_LAST = CNT_W'(`FILT_OPC_BITS - 1);
    localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(HDR_W - 1);

    // Bit 0 metastable stage, bit 1 synchronized, bit 2 previous value
    logic [2:0]              sck_q;
    logic [2:0]              csb_q;
    logic [1:0]              sd0_q;
    logic [CNT_W-1:0]        bit_cnt_q;
    logic [`FILT_ADDR_W-2:0] hdr_q;
    logic [`FILT_ADDR_W-1:0] hdr_next;
    logic                    sck_rise;
    logic                    csb_fall;
    logic                    csb_rise;
    logic                    take_bit;

    assign sck_rise = sck_q[1] & ~sck_q[2] & ~csb_q[1];
    assign csb_fall = ~csb_q[1] & csb_q[2];
    assign csb_rise = csb_q[1] & ~csb_q[2];
    // Data bytes after the header are ignored
    assign take_bit = sck_rise && (bit_cnt_q <= HDR_LAST);
    assign hdr_next = {hdr_q, sd0_q[1]};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sck_q         <= 3'b000;
            csb_q         <= 3'b111;
            sd0_q         <= 2'b00;
            bit_cnt_q     <= '0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            opc_done_o    <= 1'b0;
            addr_done_o   <= 1'b0;
        end else begin
            sck_q         <= {sck_q[1:0], host_sck_i};
            csb_q         <= {csb_q[1:0], host_csb_i};
            sd0_q         <= {sd0_q[0], host_sd0_i};
            frame_start_o <= csb_fall;
            frame_end_o   <= csb_rise;
            opc_done_o    <= take_bit && (bit_cnt_q == OPC_LAST);
            addr_done_o   <= take_bit && (bit_cnt_q == HDR_LAST);
            if (csb_fall) begin
                bit_cnt_q <= '0;
            end else if (take_bit) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

    // Last bits of the shift register hold the field that just completed
    always_ff @(posedge clk_i) begin
        if (take_bit) begin
            hdr_q <= hdr_next[`FILT_ADDR_W-2:0];
            if (bit_cnt_q == OPC_LAST) begin
                opcode_o <= hdr_next[`FILT_OPC_BITS-1:0];
            end
            if (bit_cnt_q == HDR_LAST) begin
                addr_o <= hdr_next;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        opc_done_o |-> !csb_q[1]);

endmodule

// ==== hdl/opcode_classifier.sv ====
`include "filter_defines.svh"

module opcode_classifier (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        opc_done_i,
    input  logic [`FILT_OPC_BITS-1:0]   opcode_i,
    output spi_cmd_pkg::cmd_class_e     cmd_class_o,
    output filter_report_pkg::verdict_e opc_verdict_o,
    output logic                        verdict_valid_o
);

    spi_cmd_pkg::cmd_class_e     class_d;
    filter_report_pkg::verdict_e verdict_d;

    // Allow-list, anything not named here is forbidden
    always_comb begin
        case (spi_cmd_pkg::opcode_e'(opcode_i))
            spi_cmd_pkg::OPC_READ,
            spi_cmd_pkg::OPC_FAST_READ,
            spi_cmd_pkg::OPC_DOR,
            spi_cmd_pkg::OPC_QOR,
            spi_cmd_pkg::OPC_DIOR,
            spi_cmd_pkg::OPC_QIOR:   class_d = spi_cmd_pkg::CLS_READ;
            spi_cmd_pkg::OPC_WREN,
            spi_cmd_pkg::OPC_WRDI:   class_d = spi_cmd_pkg::CLS_WREN;
            spi_cmd_pkg::OPC_PP,
            spi_cmd_pkg::OPC_SE_4K,
            spi_cmd_pkg::OPC_BE_64K: class_d = spi_cmd_pkg::CLS_MODIFY;
            default:                 class_d = spi_cmd_pkg::CLS_FORBIDDEN;
        endcase
    end

    // Modify commands wait for the window check
    always_comb begin
        case (class_d)
            spi_cmd_pkg::CLS_READ,
            spi_cmd_pkg::CLS_WREN:   verdict_d = filter_report_pkg::VERD_PASS;
            spi_cmd_pkg::CLS_MODIFY: verdict_d = filter_report_pkg::VERD_NONE;
            default:                 verdict_d = filter_report_pkg::VERD_BLOCK;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmd_class_o     <= spi_cmd_pkg::CLS_FORBIDDEN;
            opc_verdict_o   <= filter_report_pkg::VERD_NONE;
            verdict_valid_o <= 1'b0;
        end else begin
            verdict_valid_o <= opc_done_i;
            if (opc_done_i) begin
                cmd_class_o   <= class_d;
                opc_verdict_o <= verdict_d;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        verdict_valid_o |=> !verdict_valid_o);

endmodule

// ==== hdl/addr_window_check.sv ====
`include "filter_defines.svh"

module addr_window_check (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        addr_done_i,
    input  logic [`FILT_ADDR_W-1:0]     addr_i,
    input  logic [`FILT_ADDR_W-1:0]     wr_base_i,
    input  logic [`FILT_ADDR_W-1:0]     wr_limit_i,
    output filter_report_pkg::verdict_e addr_verdict_o,
    output logic                        verdict_valid_o
);

    logic in_window;

    // Both bounds inclusive
    assign in_window = (addr_i >= wr_base_i) && (addr_i <= wr_limit_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_verdict_o  <= filter_report_pkg::VERD_NONE;
            verdict_valid_o <= 1'b0;
        end else begin
            verdict_valid_o <= addr_done_i;
            if (addr_done_i) begin
                if (in_window) begin
                    addr_verdict_o <= filter_report_pkg::VERD_PASS;
                end else begin
                    addr_verdict_o <= filter_report_pkg::VERD_BLOCK;
                end
            end
        end
    end

    // Software must program a non-empty window before traffic starts
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        addr_done_i |-> (wr_base_i <= wr_limit_i));

endmodule

// ==== hdl/spi_bus_gate.sv ====
`include "filter_defines.svh"

module spi_bus_gate (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               host_sck_i,
    input  logic                               host_csb_i,
    input  logic [3:0]                         host_sd_i,
    input  logic [3:0]                         host_sd_en_i,
    output logic                               flash_sck_o,
    output logic                               flash_csb_o,
    output logic [3:0]                         flash_sd_o,
    output logic [3:0]                         flash_sd_en_o,
    input  logic                               frame_start_i,
    input  logic                               frame_end_i,
    input  spi_cmd_pkg::cmd_class_e            cmd_class_i,
    input  filter_report_pkg::verdict_e        opc_verdict_i,
    input  filter_report_pkg::verdict_e        addr_verdict_i,
    input  logic                               opc_valid_i,
    input  logic                               addr_valid_i,
    input  logic [`FILT_OPC_BITS-1:0]          opcode_i,
    input  logic [`FILT_ADDR_W-1:0]            addr_i,
    output logic                               rpt_valid_o,
    input  logic                               rpt_ready_i,
    output logic [`FILT_OPC_BITS-1:0]          rpt_opcode_o,
    output logic [`FILT_ADDR_W-1:0]            rpt_addr_o,
    output filter_report_pkg::block_reason_e   rpt_reason_o,
    output logic                               rpt_overflow_o
);

    // Line bundle is {sck, csb, sd_en, sd}
    localparam int LINE_W = 10;
    localparam logic [LINE_W-1:0] LINE_IDLE = {1'b0, 1'b1, 4'h0, 4'h0};

    logic [LINE_W-1:0] dly_q [`FILT_FWD_DELAY];
    logic [LINE_W-1:0] dly_out;
    logic              in_frame_q;
    logic              lock_q;
    logic              opc_block;
    logic              addr_block;
    logic              new_block;
    logic              blocking;
    logic              rpt_fire;
    logic              rpt_load;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `FILT_FWD_DELAY; i++) begin
                dly_q[i] <= LINE_IDLE;
            end
        end else begin
            dly_q[0] <= {host_sck_i, host_csb_i, host_sd_en_i, host_sd_i};
            for (int i = 1; i < `FILT_FWD_DELAY; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign dly_out = dly_q[`FILT_FWD_DELAY-1];

    // Address verdict only counts for modify commands
    assign opc_block  = opc_valid_i && (opc_verdict_i == filter_report_pkg::VERD_BLOCK);
    assign addr_block = addr_valid_i && (cmd_class_i == spi_cmd_pkg::CLS_MODIFY) &&
                        (addr_verdict_i == filter_report_pkg::VERD_BLOCK);
    assign new_block  = in_frame_q && !lock_q && (opc_block || addr_block);
    // The verdict lands together with the deciding sck edge, so the edge is cut
    assign blocking   = lock_q || new_block;

    assign flash_sck_o   = dly_out[9] & ~blocking;
    assign flash_csb_o   = dly_out[8] | blocking;
    assign flash_sd_en_o = blocking ? 4'h0 : dly_out[7:4];
    assign flash_sd_o    = blocking ? 4'h0 : dly_out[3:0];

    assign rpt_fire = rpt_valid_o && rpt_ready_i;
    assign rpt_load = new_block && (!rpt_valid_o || rpt_fire);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            in_frame_q     <= 1'b0;
            lock_q         <= 1'b0;
            rpt_valid_o    <= 1'b0;
            rpt_overflow_o <= 1'b0;
        end else begin
            if (frame_end_i) begin
                in_frame_q <= 1'b0;
                lock_q     <= 1'b0;
            end else begin
                if (frame_start_i) begin
                    in_frame_q <= 1'b1;
                end
                if (new_block) begin
                    lock_q <= 1'b1;
                end
            end
            if (rpt_load) begin
                rpt_valid_o    <= 1'b1;
                rpt_overflow_o <= 1'b0;
            end else if (new_block) begin
                // Pending report still waits, this violation is lost
                rpt_overflow_o <= 1'b1;
            end else if (rpt_fire) begin
                rpt_valid_o    <= 1'b0;
                rpt_overflow_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rpt_load) begin
            rpt_opcode_o <= opcode_i;
            if (opc_block) begin
                rpt_reason_o <= filter_report_pkg::RSN_OPCODE;
                rpt_addr_o   <= '0;
            end else begin
                rpt_reason_o <= filter_report_pkg::RSN_ADDRESS;
                rpt_addr_o   <= addr_i;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rpt_valid_o && !rpt_ready_i |=>
            rpt_valid_o && $stable({rpt_opcode_o, rpt_addr_o, rpt_reason_o}));

endmodule

// ==== hdl/spi_flash_guard.sv ====
`include "filter_defines.svh"

module spi_flash_guard (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             host_sck_i,
    input  logic                             host_csb_i,
    input  logic [3:0]                       host_sd_i,
    input  logic [3:0]                       host_sd_en_i,
    output logic [3:0]                       host_sdi_o,
    output logic                             flash_sck_o,
    output logic                             flash_csb_o,
    output logic [3:0]                       flash_sd_o,
    output logic [3:0]                       flash_sd_en_o,
    input  logic [3:0]                       flash_sdi_i,
    input  logic [`FILT_ADDR_W-1:0]          wr_base_i,
    input  logic [`FILT_ADDR_W-1:0]          wr_limit_i,
    output logic                             rpt_valid_o,
    input  logic                             rpt_ready_i,
    output logic [`FILT_OPC_BITS-1:0]        rpt_opcode_o,
    output logic [`FILT_ADDR_W-1:0]          rpt_addr_o,
    output filter_report_pkg::block_reason_e rpt_reason_o,
    output logic                             rpt_overflow_o
);

    logic                        frame_start;
    logic                        frame_end;
    logic                        opc_done;
    logic                        addr_done;
    logic [`FILT_OPC_BITS-1:0]   opcode;
    logic [`FILT_ADDR_W-1:0]     addr;
    spi_cmd_pkg::cmd_class_e     cmd_class;
    filter_report_pkg::verdict_e opc_verdict;
    filter_report_pkg::verdict_e addr_verdict;
    logic                        opc_valid;
    logic                        addr_valid;

    // Read data from the flash is never filtered
    assign host_sdi_o = flash_sdi_i;

    spi_bit_sampler u_sampler (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .host_sck_i    (host_sck_i),
        .host_csb_i    (host_csb_i),
        .host_sd0_i    (host_sd_i[0]),
        .frame_start_o (frame_start),
        .frame_end_o   (frame_end),
        .opc_done_o    (opc_done),
        .addr_done_o   (addr_done),
        .opcode_o      (opcode),
        .addr_o        (addr)
    );

    opcode_classifier u_classifier (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .opc_done_i      (opc_done),
        .opcode_i        (opcode),
        .cmd_class_o     (cmd_class),
        .opc_verdict_o   (opc_verdict),
        .verdict_valid_o (opc_valid)
    );

    addr_window_check u_window (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .addr_done_i     (addr_done),
        .addr_i          (addr),
        .wr_base_i       (wr_base_i),
        .wr_limit_i      (wr_limit_i),
        .addr_verdict_o  (addr_verdict),
        .verdict_valid_o (addr_valid)
    );

    spi_bus_gate u_gate (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .host_sck_i     (host_sck_i),
        .host_csb_i     (host_csb_i),
        .host_sd_i      (host_sd_i),
        .host_sd_en_i   (host_sd_en_i),
        .flash_sck_o    (flash_sck_o),
        .flash_csb_o    (flash_csb_o),
        .flash_sd_o     (flash_sd_o),
        .flash_sd_en_o  (flash_sd_en_o),
        .frame_start_i  (frame_start),
        .frame_end_i    (frame_end),
        .cmd_class_i    (cmd_class),
        .opc_verdict_i  (opc_verdict),
        .addr_verdict_i (addr_verdict),
        .opc_valid_i    (opc_valid),
        .addr_valid_i   (addr_valid),
        .opcode_i       (opcode),
        .addr_i         (addr),
        .rpt_valid_o    (rpt_valid_o),
        .rpt_ready_i    (rpt_ready_i),
        .rpt_opcode_o   (rpt_opcode_o),
        .rpt_addr_o     (rpt_addr_o),
        .rpt_reason_o   (rpt_reason_o),
        .rpt_overflow_o (rpt_overflow_o)
    );

endmodule

// ==== tests/guard_cases.svh ====
`ifndef GUARD_CASES_SVH
`define GUARD_CASES_SVH

// One row per frame: name, opcode, address, flash sck edges, report expected,
// report reason and report address
localparam int NUM_CASES = 8;

string       case_name  [NUM_CASES] = '{
    "read_03", "fast_read_0b", "wren_06", "chip_erase_c7",
    "wrsr_01", "pp_in_window", "pp_above_window", "se_below_window"
};
logic [7:0]  case_opc   [NUM_CASES] = '{
    8'h03, 8'h0B, 8'h06, 8'hC7, 8'h01, 8'h02, 8'h02, 8'h20
};
logic [23:0] case_addr  [NUM_CASES] = '{
    24'h000100, 24'h3456AB, 24'h000000, 24'h000000,
    24'h000000, 24'h180000, 24'h300000, 24'h0FF000
};
int          case_edges [NUM_CASES] = '{48, 48, 48, 7, 7, 48, 31, 31};
logic        case_rpt   [NUM_CASES] = '{0, 0, 0, 1, 1, 0, 1, 1};
logic        case_rsn   [NUM_CASES] = '{
    filter_report_pkg::RSN_OPCODE,  filter_report_pkg::RSN_OPCODE,
    filter_report_pkg::RSN_OPCODE,  filter_report_pkg::RSN_OPCODE,
    filter_report_pkg::RSN_OPCODE,  filter_report_pkg::RSN_ADDRESS,
    filter_report_pkg::RSN_ADDRESS, filter_report_pkg::RSN_ADDRESS
};

task automatic run_case(input int idx);
    logic [FRAME_BITS-1:0] frame;
    logic [63:0]           seen;
    bit                    ok;
    int                    xfers;
    start_test(case_name[idx]);
    frame = make_frame(case_opc[idx], case_addr[idx]);
    send_frame(frame);
    // Bits that should have reached the flash before any cut
    seen = 64'(frame) >> (FRAME_BITS - case_edges[idx]);
    check_value("flash_edges", case_edges[idx], mon_edges);
    check_value("flash_bits", seen, mon_bits);
    if (case_rpt[idx]) begin
        wait_report_valid(ok);
        if (ok) begin
            check_value("rpt_opcode", case_opc[idx], rpt_opcode_o);
            check_value("rpt_reason", case_rsn[idx], rpt_reason_o);
            check_value("rpt_overflow", 0, rpt_overflow_o);
            if (case_rsn[idx] == filter_report_pkg::RSN_ADDRESS) begin
                check_value("rpt_addr", case_addr[idx], rpt_addr_o);
            end
            // Random gap before software picks it up
            repeat ($urandom_range(0, 3)) @(negedge clk_i);
            check_value("rpt_pending", 1, rpt_valid_o);
            accept_report(xfers);
            check_value("transfers", 1, xfers);
        end
    end else begin
        check_value("rpt_valid", 0, rpt_valid_o);
    end
    end_test();
endtask

task automatic run_table();
    int i;
    for (i = 0; i < NUM_CASES; i++) begin
        run_case(i);
    end
endtask

`endif

// ==== tests/tb_spi_flash_guard.sv ====
`include "filter_defines.svh"

module tb_spi_flash_guard;

    localparam int HALF_PERIOD = 10;
    localparam int DATA_BYTES  = 2;
    localparam int DATA_W      = 8 * DATA_BYTES;
    localparam int HDR_BITS    = `FILT_OPC_BITS + `FILT_ADDR_W;
    localparam int FRAME_BITS  = HDR_BITS + 8 * DATA_BYTES;
    localparam int FRAME_GAP   = 20;
    localparam int RPT_TIMEOUT = 200;

    logic                             clk_i;
    logic                             rst_ni;
    logic                             host_sck_i;
    logic                             host_csb_i;
    logic [3:0]                       host_sd_i;
    logic [3:0]                       host_sd_en_i;
    logic [3:0]                       host_sdi_o;
    logic                             flash_sck_o;
    logic                             flash_csb_o;
    logic [3:0]                       flash_sd_o;
    logic [3:0]                       flash_sd_en_o;
    logic [3:0]                       flash_sdi_i;
    logic [`FILT_ADDR_W-1:0]          wr_base_i;
    logic [`FILT_ADDR_W-1:0]          wr_limit_i;
    logic                             rpt_valid_o;
    logic                             rpt_ready_i;
    logic [`FILT_OPC_BITS-1:0]        rpt_opcode_o;
    logic [`FILT_ADDR_W-1:0]          rpt_addr_o;
    filter_report_pkg::block_reason_e rpt_reason_o;
    logic                             rpt_overflow_o;

    // Flash-side monitor state
    int          mon_edges    = 0;
    logic [63:0] mon_bits     = '0;
    logic        mon_sck_prev = 1'b0;
    logic        mon_csb_prev = 1'b1;

    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_ok;

    spi_flash_guard u_dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .host_sck_i     (host_sck_i),
        .host_csb_i     (host_csb_i),
        .host_sd_i      (host_sd_i),
        .host_sd_en_i   (host_sd_en_i),
        .host_sdi_o     (host_sdi_o),
        .flash_sck_o    (flash_sck_o),
        .flash_csb_o    (flash_csb_o),
        .flash_sd_o     (flash_sd_o),
        .flash_sd_en_o  (flash_sd_en_o),
        .flash_sdi_i    (flash_sdi_i),
        .wr_base_i      (wr_base_i),
        .wr_limit_i     (wr_limit_i),
        .rpt_valid_o    (rpt_valid_o),
        .rpt_ready_i    (rpt_ready_i),
        .rpt_opcode_o   (rpt_opcode_o),
        .rpt_addr_o     (rpt_addr_o),
        .rpt_reason_o   (rpt_reason_o),
        .rpt_overflow_o (rpt_overflow_o)
    );

    always #50 clk_i = ~clk_i;

    // Flash lines sampled mid-cycle between gate updates
    always @(negedge clk_i) begin
        if (!flash_csb_o && mon_csb_prev) begin
            mon_edges <= 0;
            mon_bits  <= '0;
        end else if (!flash_csb_o && flash_sck_o && !mon_sck_prev) begin
            mon_edges <= mon_edges + 1;
            mon_bits  <= {mon_bits[62:0], flash_sd_o[0]};
        end
        mon_sck_prev <= flash_sck_o;
        mon_csb_prev <= flash_csb_o;
    end

    task automatic check_value(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
                     cur_test, field, expected, actual);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            tests_ok++;
            $display("%-20s ok", cur_test);
        end else begin
            $display("%-20s FAIL, %0d errors", cur_test, test_errs);
        end
    endtask

    // Header MSB first followed by random data bytes
    function automatic logic [FRAME_BITS-1:0] make_frame(input logic [7:0] opc,
                                                         input logic [23:0] addr);
        logic [DATA_W-1:0] data;
        data = DATA_W'($urandom);
        return {opc, addr, data};
    endfunction

    // Single-line SPI host in mode 0
    task automatic send_frame(input logic [FRAME_BITS-1:0] frame);
        int i;
        @(negedge clk_i);
        host_csb_i   = 1'b0;
        host_sd_en_i = 4'b0001;
        for (i = FRAME_BITS - 1; i >= 0; i--) begin
            host_sd_i[0] = frame[i];
            repeat (HALF_PERIOD) @(negedge clk_i);
            host_sck_i = 1'b1;
            repeat (HALF_PERIOD) @(negedge clk_i);
            host_sck_i = 1'b0;
        end
        repeat (HALF_PERIOD) @(negedge clk_i);
        host_csb_i   = 1'b1;
        host_sd_en_i = 4'b0000;
        host_sd_i    = 4'h0;
        repeat (FRAME_GAP) @(negedge clk_i);
    endtask

    task automatic wait_report_valid(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < RPT_TIMEOUT && !ok; n++) begin
            if (rpt_valid_o) begin
                ok = 1'b1;
            end else begin
                @(negedge clk_i);
            end
        end
        if (!ok) begin
            $display("%s: no violation report appeared within %0d cycles",
                     cur_test, RPT_TIMEOUT);
            test_errs++;
            total_errs++;
        end
    endtask

    // Raise ready and count transfers until valid drops
    task automatic accept_report(output int xfers);
        int n;
        bit dropped;
        xfers   = 0;
        dropped = 1'b0;
        rpt_ready_i = 1'b1;
        for (n = 0; n < RPT_TIMEOUT && !dropped; n++) begin
            if (rpt_valid_o) begin
                xfers++;
            end
            @(negedge clk_i);
            if (!rpt_valid_o) begin
                dropped = 1'b1;
            end
        end
        rpt_ready_i = 1'b0;
        if (!dropped) begin
            $display("%s: report stayed valid for %0d cycles with ready high",
                     cur_test, RPT_TIMEOUT);
            test_errs++;
            total_errs++;
        end
    endtask

    // Read data lines from the flash go straight back to the host
    task automatic run_sdi_passthrough();
        int n;
        start_test("sdi_passthrough");
        for (n = 0; n < 16; n++) begin
            flash_sdi_i = 4'(n);
            @(negedge clk_i);
            check_value("host_sdi", n, host_sdi_o);
        end
        flash_sdi_i = 4'h0;
        end_test();
    endtask

    task automatic run_backpressure();
        bit ok;
        int xfers;
        start_test("backpressure");
        rpt_ready_i = 1'b0;
        send_frame(make_frame(8'hC7, 24'h000000));
        wait_report_valid(ok);
        if (ok) begin
            check_value("first_opcode", 8'hC7, rpt_opcode_o);
            check_value("first_overflow", 0, rpt_overflow_o);
            send_frame(make_frame(8'h01, 24'h000000));
            check_value("second_edges", 7, mon_edges);
            check_value("held_valid", 1, rpt_valid_o);
            check_value("held_opcode", 8'hC7, rpt_opcode_o);
            check_value("held_reason", filter_report_pkg::RSN_OPCODE, rpt_reason_o);
            check_value("overflow", 1, rpt_overflow_o);
            accept_report(xfers);
            check_value("transfers", 1, xfers);
            repeat (3) @(negedge clk_i);
            check_value("valid_after", 0, rpt_valid_o);
        end
        end_test();
    endtask

    `include "guard_cases.svh"

    initial begin
        void'($urandom(32'h9a60327f));
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        host_sck_i   = 1'b0;
        host_csb_i   = 1'b1;
        host_sd_i    = 4'h0;
        host_sd_en_i = 4'h0;
        flash_sdi_i  = 4'h0;
        wr_base_i    = 24'h100000;
        wr_limit_i   = 24'h1FFFFF;
        rpt_ready_i  = 1'b0;
        total_errs   = 0;
        tests_run    = 0;
        tests_ok     = 0;

        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);

        start_test("reset_state");
        check_value("flash_csb", 1, flash_csb_o);
        check_value("flash_sck", 0, flash_sck_o);
        check_value("flash_sd_en", 0, flash_sd_en_o);
        check_value("rpt_valid", 0, rpt_valid_o);
        end_test();

        run_sdi_passthrough();
        run_table();
        run_backpressure();

        $display("tests run %0d, passed %0d, failing %0d, check errors %0d",
                 tests_run, tests_ok, tests_run - tests_ok, total_errs);
        if (total_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== spi_flash_guard.f ====
+incdir+hdl
+incdir+tests
hdl/spi_cmd_pkg.sv
hdl/filter_report_pkg.sv
hdl/spi_bit_sampler.sv
hdl/opcode_classifier.sv
hdl/addr_window_check.sv
hdl/spi_bus_gate.sv
hdl/spi_flash_guard.sv
tests/tb_spi_flash_guard.sv
